// ==== include/vram_defs.svh ====
`ifndef VRAM_DEFS_SVH
`define VRAM_DEFS_SVH

// cpu window onto video ram
`define VRAM_BASE 16'h8000
`define VRAM_LAST 16'h9FFF

// oam dma source page register
`define DMA_REG 16'hFF46

`define OAM_BYTES 160 // bytes per dma transfer

`define VRAM_AW 13 // 8 KiB

// pages that map onto video ram
`define DMA_PAGE_MIN 8'h80
`define DMA_PAGE_MAX 8'h9F

`endif

// ==== src/vram_pkg.sv ====
`default_nettype none

`include "vram_defs.svh"

package vram_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [`VRAM_AW-1:0] vram_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [7:0] oam_index_t;

	typedef struct packed {
		logic valid;
		logic write;
		vram_addr_t addr;
		byte_t wdata;
	} vram_req_t;

	typedef struct packed {
		logic valid;
		byte_t data;
	} vram_rd_t;

	typedef struct packed {
		logic valid;
		byte_t page; // high byte of source address
	} dma_cmd_t;

	typedef struct packed {
		logic valid;
		oam_index_t index;
		byte_t data;
	} oam_wr_t;

	typedef enum logic [1:0] {
		own_none,
		own_ppu,
		own_dma,
		own_cpu
	} bus_owner_e;

	typedef enum logic [1:0] {
		apb_idle,
		apb_wait, // vram request pending grant
		apb_data  // read granted, data due
	} apb_state_e;

endpackage

`default_nettype wire

// ==== src/vram_ram.sv ====
`default_nettype none

`include "vram_defs.svh"

module vram_ram(
		input  logic phi,

		input  logic mem_cs,
		input  logic mem_we,
		input  vram_pkg::vram_addr_t mem_addr,
		input  vram_pkg::byte_t mem_wdata,
		output vram_pkg::byte_t mem_rdata
	);

	vram_pkg::byte_t mem [0:(2**`VRAM_AW)-1];

	// single port, read data one cycle after select
	always_ff @(posedge phi) begin
		if (mem_cs) begin
			if (mem_we)
				mem[mem_addr] <= mem_wdata;
			else
				mem_rdata <= mem[mem_addr];
		end
	end

endmodule

`default_nettype wire

// ==== src/vram_bus_ctrl.sv ====
`default_nettype none

module vram_bus_ctrl(
		input  logic phi,
		input  logic rst_n,

		input  vram_pkg::vram_req_t ppu_req,
		input  vram_pkg::vram_req_t cpu_req,
		input  vram_pkg::vram_req_t dma_req,

		output logic cpu_grant,
		output logic dma_grant,

		output vram_pkg::vram_rd_t ppu_rd,
		output vram_pkg::vram_rd_t cpu_rd,
		output vram_pkg::vram_rd_t dma_rd,

		output logic mem_cs,
		output logic mem_we,
		output vram_pkg::vram_addr_t mem_addr,
		output vram_pkg::byte_t mem_wdata,
		input  vram_pkg::byte_t mem_rdata
	);

	vram_pkg::bus_owner_e owner;
	vram_pkg::bus_owner_e rd_owner; // who read last cycle
	vram_pkg::vram_req_t sel;

	// fixed priority, ppu first
	always_comb begin
		owner = vram_pkg::own_none;
		if (ppu_req.valid)
			owner = vram_pkg::own_ppu;
		else if (dma_req.valid)
			owner = vram_pkg::own_dma;
		else if (cpu_req.valid)
			owner = vram_pkg::own_cpu;
	end

	always_comb begin
		sel = '0;
		case (owner)
			vram_pkg::own_ppu: begin
				sel = ppu_req;
				sel.write = 1'b0; // fetcher only reads
			end
			vram_pkg::own_dma:
				sel = dma_req;
			vram_pkg::own_cpu:
				sel = cpu_req;
			default:
				sel = '0;
		endcase
	end

	assign cpu_grant = (owner == vram_pkg::own_cpu);
	assign dma_grant = (owner == vram_pkg::own_dma);

	assign mem_cs    = sel.valid;
	assign mem_we    = sel.valid && sel.write;
	assign mem_addr  = sel.addr;
	assign mem_wdata = sel.wdata;

	always_ff @(posedge phi or negedge rst_n) begin
		if (!rst_n)
			rd_owner <= vram_pkg::own_none;
		else if (mem_cs && !mem_we)
			rd_owner <= owner;
		else
			rd_owner <= vram_pkg::own_none;
	end

	// ram data is shared, only the valid flags steer it
	assign ppu_rd.valid = (rd_owner == vram_pkg::own_ppu);
	assign ppu_rd.data  = mem_rdata;

	assign cpu_rd.valid = (rd_owner == vram_pkg::own_cpu);
	assign cpu_rd.data  = mem_rdata;

	assign dma_rd.valid = (rd_owner == vram_pkg::own_dma);
	assign dma_rd.data  = mem_rdata;

endmodule

`default_nettype wire

// ==== src/vram_oam_dma.sv ====
`default_nettype none

`include "vram_defs.svh"

module vram_oam_dma(
		input  logic phi,
		input  logic rst_n,

		input  vram_pkg::dma_cmd_t dma_cmd,

		output vram_pkg::vram_req_t dma_req,
		input  logic dma_grant,
		input  vram_pkg::vram_rd_t dma_rd,

		output vram_pkg::oam_wr_t oam_wr,
		output logic dma_active
	);

	vram_pkg::byte_t page;
	vram_pkg::oam_index_t rd_idx; // next byte to request
	vram_pkg::oam_index_t wr_idx; // next byte to return

	logic page_ok;
	logic start;
	logic last_ret;

	assign page_ok  = (dma_cmd.page >= `DMA_PAGE_MIN) && (dma_cmd.page <= `DMA_PAGE_MAX);
	assign start    = dma_cmd.valid && page_ok;
	assign last_ret = dma_rd.valid && (wr_idx == `OAM_BYTES - 1);

	// no request in a restart cycle, so nothing stale is in flight after it
	assign dma_req.valid = dma_active && (rd_idx < `OAM_BYTES) && !start;
	assign dma_req.write = 1'b0;
	assign dma_req.addr  = {page[4:0], rd_idx}; // page minus 80h, times 256
	assign dma_req.wdata = 8'h00;

	assign oam_wr.valid = dma_rd.valid;
	assign oam_wr.index = wr_idx;
	assign oam_wr.data  = dma_rd.data;

	always_ff @(posedge phi or negedge rst_n) begin
		if (!rst_n) begin
			dma_active <= 1'b0;
			rd_idx     <= '0;
			wr_idx     <= '0;
		end else begin
			if (dma_grant)
				rd_idx <= rd_idx + 8'd1;
			if (dma_rd.valid)
				wr_idx <= wr_idx + 8'd1;
			if (last_ret)
				dma_active <= 1'b0;

			// restart wins over any count
			if (start) begin
				dma_active <= 1'b1;
				rd_idx     <= '0;
				wr_idx     <= '0;
			end
		end
	end

	// source page is payload
	always_ff @(posedge phi) begin
		if (start)
			page <= dma_cmd.page;
	end

endmodule

`default_nettype wire

// ==== src/vram_cpu_port.sv ====
`default_nettype none

`include "vram_defs.svh"

module vram_cpu_port(
		input  logic phi,
		input  logic rst_n,

		input  logic psel,
		input  logic penable,
		input  logic pwrite,
		input  vram_pkg::cpu_addr_t paddr,
		input  vram_pkg::byte_t pwdata,
		output vram_pkg::byte_t prdata,
		output logic pready,
		output logic pslverr,

		input  logic ppu_busy,

		output vram_pkg::vram_req_t cpu_req,
		input  logic cpu_grant,
		input  vram_pkg::vram_rd_t cpu_rd,

		output vram_pkg::dma_cmd_t dma_cmd
	);

	vram_pkg::apb_state_e state, state_nx;
	vram_pkg::byte_t dma_page;

	logic access;
	logic req_phase;
	logic vram_hit;
	logic dma_hit;

	assign access    = psel && penable;
	assign req_phase = access && (state != vram_pkg::apb_data);
	assign vram_hit  = (paddr >= `VRAM_BASE) && (paddr <= `VRAM_LAST);
	assign dma_hit   = (paddr == `DMA_REG);

	// blocked accesses never reach the bus
	assign cpu_req.valid = req_phase && vram_hit && !ppu_busy;
	assign cpu_req.write = pwrite;
	assign cpu_req.addr  = paddr[`VRAM_AW-1:0];
	assign cpu_req.wdata = pwdata;

	assign dma_cmd.valid = req_phase && dma_hit && pwrite;
	assign dma_cmd.page  = pwdata;

	always_comb begin
		pready  = 1'b0;
		pslverr = 1'b0;
		prdata  = 8'hFF;
		if (state == vram_pkg::apb_data) begin
			pready = cpu_rd.valid;
			prdata = cpu_rd.data;
		end else if (access) begin
			if (vram_hit) begin
				if (ppu_busy)
					pready = 1'b1; // reads give FF, writes dropped
				else
					pready = cpu_grant && pwrite;
			end else if (dma_hit) begin
				pready = 1'b1;
				prdata = dma_page;
			end else begin
				pready  = 1'b1;
				pslverr = 1'b1;
			end
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			vram_pkg::apb_idle, vram_pkg::apb_wait: begin
				state_nx = vram_pkg::apb_idle;
				if (access && vram_hit && !ppu_busy) begin
					if (!cpu_grant)
						state_nx = vram_pkg::apb_wait;
					else if (!pwrite)
						state_nx = vram_pkg::apb_data;
				end
			end
			vram_pkg::apb_data:
				if (cpu_rd.valid)
					state_nx = vram_pkg::apb_idle;
			default:
				state_nx = vram_pkg::apb_idle;
		endcase
	end

	always_ff @(posedge phi or negedge rst_n) begin
		if (!rst_n) begin
			state    <= vram_pkg::apb_idle;
			dma_page <= 8'hFF;
		end else begin
			state <= state_nx;
			if (dma_cmd.valid)
				dma_page <= pwdata; // kept even if out of range
		end
	end

endmodule

`default_nettype wire

// ==== src/vram_subsystem.sv ====
`default_nettype none

module vram_subsystem(
		input  logic phi,
		input  logic rst_n,

		input  logic psel,
		input  logic penable,
		input  logic pwrite,
		input  vram_pkg::cpu_addr_t paddr,
		input  vram_pkg::byte_t pwdata,
		output vram_pkg::byte_t prdata,
		output logic pready,
		output logic pslverr,

		input  logic ppu_busy,
		input  vram_pkg::vram_req_t ppu_req,
		output vram_pkg::vram_rd_t ppu_rd,

		output vram_pkg::oam_wr_t oam_wr,
		output logic dma_active
	);

	vram_pkg::vram_req_t cpu_req;
	vram_pkg::vram_req_t dma_req;
	vram_pkg::dma_cmd_t dma_cmd;
	vram_pkg::vram_rd_t cpu_rd;
	vram_pkg::vram_rd_t dma_rd;
	logic cpu_grant;
	logic dma_grant;

	logic mem_cs;
	logic mem_we;
	vram_pkg::vram_addr_t mem_addr;
	vram_pkg::byte_t mem_wdata;
	vram_pkg::byte_t mem_rdata;

	vram_cpu_port u_cpu_port(
		.phi(phi),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.ppu_busy(ppu_busy),
		.cpu_req(cpu_req),
		.cpu_grant(cpu_grant),
		.cpu_rd(cpu_rd),
		.dma_cmd(dma_cmd)
	);

	vram_oam_dma u_oam_dma(
		.phi(phi),
		.rst_n(rst_n),
		.dma_cmd(dma_cmd),
		.dma_req(dma_req),
		.dma_grant(dma_grant),
		.dma_rd(dma_rd),
		.oam_wr(oam_wr),
		.dma_active(dma_active)
	);

	vram_bus_ctrl u_bus_ctrl(
		.phi(phi),
		.rst_n(rst_n),
		.ppu_req(ppu_req),
		.cpu_req(cpu_req),
		.dma_req(dma_req),
		.cpu_grant(cpu_grant),
		.dma_grant(dma_grant),
		.ppu_rd(ppu_rd),
		.cpu_rd(cpu_rd),
		.dma_rd(dma_rd),
		.mem_cs(mem_cs),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	vram_ram u_ram(
		.phi(phi),
		.mem_cs(mem_cs),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== test/tb_vram.sv ====
`default_nettype none

`include "vram_defs.svh"

module tb_vram;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int wait_limit = 2000; // cycles

	logic phi = 1'b0;
	logic rst_n = 1'b0;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	vram_pkg::cpu_addr_t paddr = '0;
	vram_pkg::byte_t pwdata = '0;
	logic ppu_busy = 1'b0;
	vram_pkg::vram_req_t ppu_req = '0;
	vram_pkg::byte_t prdata;
	logic pready;
	logic pslverr;
	vram_pkg::vram_rd_t ppu_rd;
	vram_pkg::oam_wr_t oam_wr;
	logic dma_active;

	integer seed = 32'h54d84bd2;
	int errors = 0;
	int timeouts = 0;
	logic ppu_en = 1'b0;

	vram_pkg::byte_t shadow [0:(2**`VRAM_AW)-1]; // expected video ram contents
	vram_pkg::byte_t dma_shadow;
	vram_pkg::byte_t cur_page;
	vram_pkg::byte_t ppu_exp;
	vram_pkg::byte_t exp_rd;
	vram_pkg::byte_t exp_oam;
	int oam_cnt;
	logic done_q;
	logic access;
	logic vram_win;
	logic dma_win;
	logic vram_rd_done;
	logic dma_go;
	logic bad_go;

	vram_subsystem dut(.*);

	always #5 phi = ~phi;

	assign access       = psel && penable;
	assign vram_win     = (paddr >= `VRAM_BASE) && (paddr <= `VRAM_LAST);
	assign dma_win      = (paddr == `DMA_REG);
	assign vram_rd_done = access && pready && !pwrite && vram_win && !ppu_busy;
	assign dma_go       = access && pready && pwrite && dma_win &&
		(pwdata >= `DMA_PAGE_MIN) && (pwdata <= `DMA_PAGE_MAX);
	assign bad_go       = access && pready && pwrite && dma_win && !dma_go;
	assign exp_rd       = shadow[vram_pkg::vram_addr_t'(paddr - `VRAM_BASE)];
	// page offset times 256 plus byte count
	assign exp_oam = shadow[vram_pkg::vram_addr_t'((int'(cur_page) - int'(`DMA_PAGE_MIN)) * 256
		+ oam_cnt)];

	always @(posedge phi or negedge rst_n) begin
		if (!rst_n) begin
			done_q     <= 1'b0;
			dma_shadow <= 8'hFF;
			cur_page   <= `DMA_PAGE_MIN;
			ppu_exp    <= '0;
			oam_cnt    <= 0;
		end else begin
			done_q <= access && pready;
			if (access && pready && pwrite && vram_win && !ppu_busy)
				shadow[vram_pkg::vram_addr_t'(paddr - `VRAM_BASE)] <= pwdata;
			if (access && pready && pwrite && dma_win)
				dma_shadow <= pwdata;
			if (ppu_req.valid)
				ppu_exp <= shadow[ppu_req.addr];
			if (dma_go) begin
				cur_page <= pwdata;
				oam_cnt  <= 0;
			end else if (oam_wr.valid)
				oam_cnt <= oam_cnt + 1;
		end
	end

	task automatic report_mismatch(input string name, input vram_pkg::byte_t expected,
			input vram_pkg::byte_t actual);
		errors++;
		$display("Error %s expected %h actual %h", name, expected, actual);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	assert property (@(posedge phi) disable iff (!rst_n) vram_rd_done |-> prdata == exp_rd)
		else report_mismatch("vram_read", $sampled(exp_rd), $sampled(prdata));
	assert property (@(posedge phi) disable iff (!rst_n) vram_rd_done |-> !dma_active)
		else report_failure("cpu video ram read finished while dma was still active");
	assert property (@(posedge phi) disable iff (!rst_n)
			access && $past(psel && !penable) && vram_win && ppu_busy |-> pready)
		else report_failure("blocked video ram access missed its first access cycle");
	assert property (@(posedge phi) disable iff (!rst_n)
			access && pready && !pwrite && vram_win && ppu_busy |-> prdata == 8'hFF)
		else report_mismatch("blocked_read", 8'hFF, $sampled(prdata));
	assert property (@(posedge phi) disable iff (!rst_n) access && pready && vram_win |-> !pslverr)
		else report_failure("video ram access ended with pslverr");
	assert property (@(posedge phi) disable iff (!rst_n) ppu_rd.valid == $past(ppu_req.valid))
		else report_failure("ppu_rd valid did not follow ppu_req by one cycle");
	assert property (@(posedge phi) disable iff (!rst_n) ppu_rd.valid |-> ppu_rd.data == ppu_exp)
		else report_mismatch("ppu_read", $sampled(ppu_exp), $sampled(ppu_rd.data));
	assert property (@(posedge phi) disable iff (!rst_n)
			access && !vram_win && !dma_win |-> pready && pslverr && prdata == 8'hFF)
		else report_failure("unmapped access did not end at once with pslverr and FF");
	assert property (@(posedge phi) disable iff (!rst_n) access && dma_win |-> pready && !pslverr)
		else report_failure("dma register access did not end at once without pslverr");
	assert property (@(posedge phi) disable iff (!rst_n)
			access && dma_win && !pwrite |-> prdata == dma_shadow)
		else report_mismatch("dma_reg_read", $sampled(dma_shadow), $sampled(prdata));
	assert property (@(posedge phi) disable iff (!rst_n) oam_wr.valid |-> dma_active)
		else report_failure("oam write seen while dma was idle");
	assert property (@(posedge phi) disable iff (!rst_n)
			oam_wr.valid |-> int'(oam_wr.index) == oam_cnt)
		else report_mismatch("oam_index", $sampled(oam_cnt[7:0]), $sampled(oam_wr.index));
	assert property (@(posedge phi) disable iff (!rst_n) oam_wr.valid |-> oam_wr.data == exp_oam)
		else report_mismatch("oam_data", $sampled(exp_oam), $sampled(oam_wr.data));
	assert property (@(posedge phi) disable iff (!rst_n) $past(dma_go) |-> dma_active)
		else report_failure("dma_active did not rise after a valid page write");
	assert property (@(posedge phi) disable iff (!rst_n)
			$fell(dma_active) |-> $past(oam_wr.valid && oam_cnt == `OAM_BYTES - 1))
		else report_failure("dma_active fell before the last oam write");
	assert property (@(posedge phi) disable iff (!rst_n)
			$past(bad_go && !dma_active) |-> !dma_active)
		else report_failure("an out of range page started a dma transfer");
	assert property (@(posedge phi)
			!rst_n |-> !(pready || pslverr || dma_active || oam_wr.valid || ppu_rd.valid))
		else report_failure("an output was high during reset");

	// one apb transfer that returns on the falling edge after pready
	task automatic apb_access(input logic wr, input vram_pkg::cpu_addr_t addr,
			input vram_pkg::byte_t data);
		int n;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge phi);
		penable = 1'b1;
		n = 0;
		@(negedge phi);
		while (!done_q && n < wait_limit) begin
			@(negedge phi);
			n++;
		end
		if (!done_q) begin
			timeouts++;
			$display("apb transfer to %h timed out without pready", addr);
		end
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_dma_done();
		int n;
		n = 0;
		while (dma_active && n < wait_limit) begin
			@(negedge phi);
			n++;
		end
		if (dma_active) begin
			timeouts++;
			$display("dma transfer did not finish in time");
		end
		assert (oam_cnt == `OAM_BYTES)
			else report_mismatch("oam_count", 8'(`OAM_BYTES), oam_cnt[7:0]);
	endtask

	task automatic drive_ppu();
		logic [31:0] r;
		forever begin
			@(negedge phi);
			r = $random(seed);
			ppu_req.valid = ppu_en && (r[1:0] == 2'b00);
			ppu_req.write = r[2]; // must be ignored
			ppu_req.addr  = r[15:3];
			ppu_req.wdata = r[23:16];
		end
	endtask

	initial begin
		vram_pkg::cpu_addr_t addrs [$];
		logic [31:0] r;
		repeat (16) @(negedge phi);
		rst_n = 1'b1;
		fork
			drive_ppu();
		join_none
		apb_access(1'b0, `DMA_REG, 8'h00);
		for (int i = 0; i < 2**`VRAM_AW; i++) begin // every byte gets a known value
			r = $random(seed);
			apb_access(1'b1, vram_pkg::cpu_addr_t'(`VRAM_BASE + i), r[7:0]);
		end
		ppu_en = 1'b1;
		for (int i = 0; i < 48; i++) begin
			r = $random(seed);
			addrs.push_back({3'b100, r[12:0]});
			apb_access(1'b1, addrs[i], r[20:13]);
		end
		addrs.push_back(`VRAM_BASE);
		addrs.push_back(`VRAM_LAST);
		foreach (addrs[i])
			apb_access(1'b0, addrs[i], 8'h00);
		ppu_busy = 1'b1; // rendering locks the cpu out
		foreach (addrs[i]) begin
			r = $random(seed);
			apb_access(r[0], addrs[i], r[8:1]);
		end
		ppu_busy = 1'b0;
		foreach (addrs[i])
			apb_access(1'b0, addrs[i], 8'h00);
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			apb_access(r[16], {1'b0, r[14:0]}, r[24:17]);
			apb_access(r[17], 16'hA000 | {4'h0, r[11:0]}, r[25:18]);
		end
		apb_access(1'b0, 16'hFF45, 8'h00);
		apb_access(1'b1, 16'hFF47, 8'h00);
		for (int k = 0; k < 2; k++) begin
			r = $random(seed);
			apb_access(1'b1, `DMA_REG, {3'b100, r[4:0]});
			wait_dma_done();
			apb_access(1'b0, `DMA_REG, 8'h00);
		end
		apb_access(1'b1, `DMA_REG, 8'h20);
		repeat (200) @(negedge phi); // window for a wrong start
		apb_access(1'b0, `DMA_REG, 8'h00);
		r = $random(seed);
		apb_access(1'b1, `DMA_REG, {3'b100, r[4:0]});
		apb_access(1'b0, {3'b100, r[17:5]}, 8'h00); // stalls behind dma
		wait_dma_done();
		repeat (4) @(negedge phi);
		$display("errors %0d timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
src/vram_pkg.sv
src/vram_ram.sv
src/vram_bus_ctrl.sv
src/vram_oam_dma.sv
src/vram_cpu_port.sv
src/vram_subsystem.sv
test/tb_vram.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_vram
RTL_TOP    := vram_subsystem
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert --Mdir $(OBJ_DIR)
PASS_MSG   := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
